// File: design/rf_prog_pkg.sv
package rf_prog_pkg;

    // One UART data byte
    typedef logic [7:0] byte_t;

    // Frame start codes for a parameter load
    localparam byte_t cmd_head_save = 8'hC2;
    localparam byte_t cmd_head_temp = 8'hC0;

    // Three-byte command codes
    localparam byte_t cmd_ret_config  = 8'hC1;
    localparam byte_t cmd_ret_version = 8'hC3;
    localparam byte_t cmd_reset       = 8'hC4;

    // Version reply, sent in this order
    localparam byte_t version_bytes [0:3] = '{8'hC3, 8'h32, 8'h27, 8'h02};

    // Reply lengths in bytes
    localparam logic [2:0] config_len  = 3'd6;
    localparam logic [2:0] version_len = 3'd4;

    // SPED after reset is 8N1 at 9600 baud
    localparam byte_t sped_reset = 8'h18;

    // Aux-low time of the self-check, in clock cycles
    localparam logic [15:0] self_check_cycles = 16'd16;

    typedef enum logic [1:0] {
        reply_config,
        reply_version,
        reply_selfcheck
    } reply_kind_e;

    // Command parser states
    typedef enum logic [3:0] {
        ps_idle,
        ps_addh,
        ps_addl,
        ps_sped,
        ps_chan,
        ps_option,
        ps_cfg_2,
        ps_cfg_3,
        ps_ver_2,
        ps_ver_3,
        ps_rst_2,
        ps_rst_3
    } parse_state_e;

    // Reply sequencer states
    typedef enum logic [2:0] {
        sq_idle,
        sq_load,
        sq_strobe,
        sq_self_check
    } seq_state_e;

endpackage

// File: design/cmd_parser.sv
module cmd_parser (
    input  logic                      mode3_clk,
    input  logic                      rst_n,
    input  logic                      prog_en,
    input  logic                      rx_valid,
    input  rf_prog_pkg::byte_t        rx_data,
    input  logic                      seq_busy,
    output logic                      reply_req,
    output rf_prog_pkg::reply_kind_e  reply_kind,
    output rf_prog_pkg::byte_t        head,
    output rf_prog_pkg::byte_t        addh,
    output rf_prog_pkg::byte_t        addl,
    output rf_prog_pkg::byte_t        sped,
    output rf_prog_pkg::byte_t        chan,
    output rf_prog_pkg::byte_t        option
);
    import rf_prog_pkg::*;

    parse_state_e state;
    logic         byte_ok;
    logic         is_frame_start;

    // Bytes only count in programming mode
    assign byte_ok        = prog_en & rx_valid;
    assign is_frame_start = (rx_data == cmd_head_temp) || (rx_data == cmd_head_save);

    // Command decode and reply request
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ps_idle;
            reply_req  <= 1'b0;
            reply_kind <= reply_config;
        end else begin
            reply_req <= 1'b0;
            if (!prog_en) begin
                state <= ps_idle;
            end else if (rx_valid) begin
                case (state)
                    ps_idle: begin
                        if (is_frame_start) begin
                            state <= ps_addh;
                        end else if (rx_data == cmd_ret_config) begin
                            state <= ps_cfg_2;
                        end else if (rx_data == cmd_ret_version) begin
                            state <= ps_ver_2;
                        end else if (rx_data == cmd_reset) begin
                            state <= ps_rst_2;
                        end
                    end
                    ps_addh:   state <= ps_addl;
                    ps_addl:   state <= ps_sped;
                    ps_sped:   state <= ps_chan;
                    ps_chan:   state <= ps_option;
                    ps_option: state <= ps_idle;
                    ps_cfg_2: begin
                        state <= (rx_data == cmd_ret_config) ? ps_cfg_3 : ps_idle;
                    end
                    ps_ver_2: begin
                        state <= (rx_data == cmd_ret_version) ? ps_ver_3 : ps_idle;
                    end
                    ps_rst_2: begin
                        state <= (rx_data == cmd_reset) ? ps_rst_3 : ps_idle;
                    end
                    // Third byte confirmed, dropped while a reply is running
                    ps_cfg_3: begin
                        state <= ps_idle;
                        if (rx_data == cmd_ret_config && !seq_busy) begin
                            reply_req  <= 1'b1;
                            reply_kind <= reply_config;
                        end
                    end
                    ps_ver_3: begin
                        state <= ps_idle;
                        if (rx_data == cmd_ret_version && !seq_busy) begin
                            reply_req  <= 1'b1;
                            reply_kind <= reply_version;
                        end
                    end
                    ps_rst_3: begin
                        state <= ps_idle;
                        if (rx_data == cmd_reset && !seq_busy) begin
                            reply_req  <= 1'b1;
                            reply_kind <= reply_selfcheck;
                        end
                    end
                    default: state <= ps_idle;
                endcase
            end
        end
    end

    // Parameter registers, written as each frame byte is sampled
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            addh   <= '0;
            addl   <= '0;
            sped   <= sped_reset;
            chan   <= '0;
            option <= '0;
        end else if (byte_ok) begin
            case (state)
                ps_idle: begin
                    if (is_frame_start) begin
                        head <= rx_data;
                    end
                end
                ps_addh:   addh   <= rx_data;
                ps_addl:   addl   <= rx_data;
                ps_sped:   sped   <= rx_data;
                ps_chan:   chan   <= rx_data;
                ps_option: option <= rx_data;
                default: ;
            endcase
        end
    end

    // Sequencer must never get a request it cannot take
    assert property (@(posedge mode3_clk) disable iff (!rst_n)
        reply_req |-> !seq_busy);

endmodule

// File: design/reply_sequencer.sv
module reply_sequencer (
    input  logic                      mode3_clk,
    input  logic                      rst_n,
    input  logic                      reply_req,
    input  rf_prog_pkg::reply_kind_e  reply_kind,
    input  rf_prog_pkg::byte_t        head,
    input  rf_prog_pkg::byte_t        addh,
    input  rf_prog_pkg::byte_t        addl,
    input  rf_prog_pkg::byte_t        sped,
    input  rf_prog_pkg::byte_t        chan,
    input  rf_prog_pkg::byte_t        option,
    output logic                      seq_busy,
    output logic                      tx_valid,
    output rf_prog_pkg::byte_t        tx_data,
    output logic                      aux
);
    import rf_prog_pkg::*;

    seq_state_e   state;
    reply_kind_e  kind_q;
    logic [2:0]   byte_idx;
    logic [2:0]   last_idx;
    logic [15:0]  check_cnt;
    byte_t        config_byte;
    byte_t        next_byte;

    // Parameter byte for the current index
    always_comb begin
        case (byte_idx)
            3'd0:    config_byte = head;
            3'd1:    config_byte = addh;
            3'd2:    config_byte = addl;
            3'd3:    config_byte = sped;
            3'd4:    config_byte = chan;
            default: config_byte = option;
        endcase
    end

    assign next_byte = (kind_q == reply_version) ? version_bytes[byte_idx[1:0]] : config_byte;
    assign last_idx  = (kind_q == reply_version) ? version_len - 3'd1 : config_len - 3'd1;

    // Busy from the cycle after the request until the reply is done
    assign seq_busy = (state != sq_idle);
    assign aux      = (state == sq_idle);

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sq_idle;
            kind_q    <= reply_config;
            byte_idx  <= '0;
            check_cnt <= '0;
        end else begin
            case (state)
                sq_idle: begin
                    if (reply_req) begin
                        kind_q   <= reply_kind;
                        byte_idx <= '0;
                        if (reply_kind == reply_selfcheck) begin
                            // Counts down to zero, one cycle per step
                            check_cnt <= self_check_cycles - 16'd1;
                            state     <= sq_self_check;
                        end else begin
                            state <= sq_load;
                        end
                    end
                end
                sq_load: begin
                    state <= sq_strobe;
                end
                sq_strobe: begin
                    if (byte_idx == last_idx) begin
                        state <= sq_idle;
                    end else begin
                        byte_idx <= byte_idx + 3'd1;
                        state    <= sq_load;
                    end
                end
                sq_self_check: begin
                    if (check_cnt == '0) begin
                        state <= sq_idle;
                    end else begin
                        check_cnt <= check_cnt - 16'd1;
                    end
                end
                default: state <= sq_idle;
            endcase
        end
    end

    // Reply byte and its strobe leave together on the edge after a load
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            tx_data  <= '0;
        end else begin
            tx_valid <= (state == sq_load);
            if (state == sq_load) begin
                tx_data <= next_byte;
            end
        end
    end

    // Strobes are spaced by at least one idle cycle
    assert property (@(posedge mode3_clk) disable iff (!rst_n)
        tx_valid |=> !tx_valid);

    assert property (@(posedge mode3_clk) disable iff (!rst_n)
        tx_valid |-> !aux);

endmodule

// File: design/rf_prog_ctrl.sv
module rf_prog_ctrl (
    input  logic                mode3_clk,
    input  logic                rst_n,
    input  logic                m0,
    input  logic                m1,
    input  logic                rx_valid,
    input  rf_prog_pkg::byte_t  rx_data,
    output logic                tx_valid,
    output rf_prog_pkg::byte_t  tx_data,
    output logic                aux,
    output rf_prog_pkg::byte_t  config_sped
);
    import rf_prog_pkg::*;

    logic        prog_en;
    logic        reply_req;
    reply_kind_e reply_kind;
    logic        seq_busy;
    byte_t       head;
    byte_t       addh;
    byte_t       addl;
    byte_t       sped;
    byte_t       chan;
    byte_t       option;

    // Mode 3 is the programming mode
    assign prog_en = m1 & m0;

    // SPED sets the host UART format
    assign config_sped = sped;

    cmd_parser u_cmd_parser (
        .mode3_clk  (mode3_clk),
        .rst_n      (rst_n),
        .prog_en    (prog_en),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .seq_busy   (seq_busy),
        .reply_req  (reply_req),
        .reply_kind (reply_kind),
        .head       (head),
        .addh       (addh),
        .addl       (addl),
        .sped       (sped),
        .chan       (chan),
        .option     (option)
    );

    reply_sequencer u_reply_sequencer (
        .mode3_clk  (mode3_clk),
        .rst_n      (rst_n),
        .reply_req  (reply_req),
        .reply_kind (reply_kind),
        .head       (head),
        .addh       (addh),
        .addl       (addl),
        .sped       (sped),
        .chan       (chan),
        .option     (option),
        .seq_busy   (seq_busy),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .aux        (aux)
    );

endmodule

// File: testbench/rf_prog_checks.svh
`ifndef RF_PROG_CHECKS_SVH
`define RF_PROG_CHECKS_SVH

// Number of compares done so far
int checks_done = 0;

// Ends the run after a failure has been described
task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1);
endtask

// Failure that is not a value mismatch
task automatic fail_run(input string reason);
    $display("ERROR at %0t: %0s", $time, reason);
    stop_run();
endtask

// Compare one UART byte
task automatic check_byte(
    input string              name,
    input rf_prog_pkg::byte_t expected,
    input rf_prog_pkg::byte_t actual
);
    checks_done++;
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %0s expected 0x%02h, actual 0x%02h",
                 $time, name, expected, actual);
        stop_run();
    end
endtask

// Compare a single control line
task automatic check_bit(
    input string name,
    input logic  expected,
    input logic  actual
);
    checks_done++;
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %0s expected %b, actual %b",
                 $time, name, expected, actual);
        stop_run();
    end
endtask

`endif

// File: testbench/tb_rf_prog_ctrl.sv
module tb_rf_prog_ctrl;
    import rf_prog_pkg::*;

    localparam int clk_period     = 4;
    localparam int reset_cycles   = 2;
    localparam int self_check_len = 16;
    localparam stim_path = "testbench/rf_prog_stimulus.txt";

    logic  mode3_clk;
    logic  rst_n;
    logic  m0;
    logic  m1;
    logic  rx_valid;
    byte_t rx_data;
    logic  tx_valid;
    byte_t tx_data;
    logic  aux;
    byte_t config_sped;

    // Reply bytes seen on the TX side
    byte_t tx_queue [$];

    integer seed;
    integer fd;
    integer rc;
    integer num_lines;
    integer limit_cycles = 0;
    reg [8*16-1:0]  op;
    reg [8*128-1:0] rest;
    byte_t exp_bytes [0:5];

    `include "rf_prog_checks.svh"

    initial mode3_clk = 1'b0;
    always #(clk_period / 2) mode3_clk = ~mode3_clk;

    rf_prog_ctrl uut (
        .mode3_clk   (mode3_clk),
        .rst_n       (rst_n),
        .m0          (m0),
        .m1          (m1),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .aux         (aux),
        .config_sped (config_sped)
    );

    // Outputs are settled by the falling edge
    always @(negedge mode3_clk) begin
        if (rst_n && tx_valid) begin
            tx_queue.push_back(tx_data);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge mode3_clk);
        $display("Timeout after %0d cycles, the stimulus never finished", limit_cycles);
        stop_run();
    end

    task count_lines();
        integer cfd;
        num_lines = 0;
        cfd = $fopen(stim_path, "r");
        if (cfd == 0) begin
            fail_run("cannot open the stimulus file");
        end
        while ($fgets(rest, cfd) != 0) begin
            num_lines = num_lines + 1;
        end
        $fclose(cfd);
    endtask

    // One hex operand of the current stimulus line
    task read_hex(output integer value);
        rc = $fscanf(fd, "%h", value);
        if (rc != 1) begin
            fail_run("a stimulus line has a missing or malformed operand");
        end
    endtask

    task set_mode(input logic [1:0] mode_bits);
        @(negedge mode3_clk);
        {m1, m0} = mode_bits;
    endtask

    // One-cycle strobe, sampled on the next rising edge
    task send_byte(input byte_t value);
        @(negedge mode3_clk);
        rx_valid = 1'b1;
        rx_data  = value;
        @(negedge mode3_clk);
        rx_valid = 1'b0;
        rx_data  = '0;
    endtask

    // Random byte that is never a command code
    task pick_filler(output byte_t value);
        value = $random(seed);
        while (value >= 8'hC0 && value <= 8'hC4) begin
            value = $random(seed);
        end
    endtask

    task idle_window(input integer cycles, input integer fillers);
        integer i;
        byte_t filler;
        for (i = 0; i < fillers; i++) begin
            pick_filler(filler);
            send_byte(filler);
        end
        for (i = 0; i < cycles; i++) begin
            @(negedge mode3_clk);
            check_bit("aux", 1'b1, aux);
            check_bit("tx_valid", 1'b0, tx_valid);
        end
        @(posedge mode3_clk);
        if (tx_queue.size() != 0) begin
            fail_run("reply bytes were sent although no reply was expected");
        end
        @(negedge mode3_clk);
    endtask

    // Starts right after the third command byte was sampled
    task expect_reply(input integer count);
        integer low_cycles;
        integer j;
        logic   strobe_due;
        byte_t  got;
        // Self-check has no bytes, only the aux-low time
        if (count == 0) begin
            low_cycles = self_check_len;
        end else begin
            low_cycles = 2 * count;
        end
        // Still idle in the cycle of the third byte
        check_bit("aux", 1'b1, aux);
        check_bit("tx_valid", 1'b0, tx_valid);
        for (j = 1; j <= low_cycles + 1; j++) begin
            @(negedge mode3_clk);
            strobe_due = (j % 2 == 0) && (j <= 2 * count);
            check_bit("aux", j > low_cycles, aux);
            check_bit("tx_valid", strobe_due, tx_valid);
        end
        if (tx_queue.size() != count) begin
            fail_run($sformatf("reply had %0d bytes where %0d were expected",
                               tx_queue.size(), count));
        end
        for (j = 0; j < count; j++) begin
            got = tx_queue.pop_front();
            check_byte("tx_data", exp_bytes[j], got);
        end
    endtask

    task execute_line();
        integer i;
        integer n;
        integer value;
        integer cycles;
        integer fillers;
        if (op == "#") begin
            rc = $fgets(rest, fd);
        end else if (op == "mode") begin
            read_hex(value);
            set_mode(value[1:0]);
        end else if (op == "byte") begin
            read_hex(n);
            for (i = 0; i < n; i++) begin
                read_hex(value);
                send_byte(value[7:0]);
            end
        end else if (op == "expect_reply") begin
            read_hex(n);
            if (n > 6) begin
                fail_run("a reply in the stimulus file is longer than six bytes");
            end
            for (i = 0; i < n; i++) begin
                read_hex(value);
                exp_bytes[i] = value[7:0];
            end
            expect_reply(n);
        end else if (op == "expect_sped") begin
            read_hex(value);
            check_byte("config_sped", value[7:0], config_sped);
        end else if (op == "idle") begin
            read_hex(cycles);
            read_hex(fillers);
            idle_window(cycles, fillers);
        end else begin
            fail_run("unknown operation in the stimulus file");
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        m0       = 1'b0;
        m1       = 1'b0;
        rx_valid = 1'b0;
        rx_data  = '0;
        seed     = 56;
        count_lines();
        limit_cycles = num_lines * 40 + 200;
        repeat (reset_cycles) @(posedge mode3_clk);
        @(negedge mode3_clk);
        rst_n = 1'b1;
        check_bit("aux", 1'b1, aux);
        check_bit("tx_valid", 1'b0, tx_valid);
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            fail_run("cannot open the stimulus file");
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            execute_line();
        end
        $fclose(fd);
        if (tx_queue.size() != 0) begin
            fail_run("reply bytes were left over at the end of the stimulus");
        end else begin
            $display("%0d checks done", checks_done);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: testbench/rf_prog_stimulus.txt
# op and operands, all numbers hex
# mode m1m0 | byte count values | expect_reply count values | expect_sped value | idle cycles fillers
mode 3
expect_sped 18
byte 3 c1 c1 c1
expect_reply 6 00 00 00 18 00 00
idle 4 2
byte 6 c0 12 34 1d 05 44
expect_sped 1d
byte 3 c1 c1 c1
expect_reply 6 c0 12 34 1d 05 44
byte 3 c3 c3 c3
expect_reply 4 c3 32 27 02
byte 3 c4 c4 c4
expect_reply 0
byte 3 c1 c1 55
idle 14 0
byte 3 c3 c4 c3
idle 14 1
mode 1
byte 6 c2 01 02 77 03 04
byte 3 c1 c1 c1
idle 14 3
expect_sped 1d
mode 2
byte 3 c3 c3 c3
idle 14 0
mode 3
byte 3 c1 c1 c1
expect_reply 6 c0 12 34 1d 05 44
expect_sped 1d

// File: build.f
+incdir+testbench
design/rf_prog_pkg.sv
design/cmd_parser.sv
design/reply_sequencer.sv
design/rf_prog_ctrl.sv
testbench/tb_rf_prog_ctrl.sv
